//--- src/iperf_stats_pkg.sv
// shared widths and status field positions, imported by the statistics RTL and its testbench
`default_nettype none

package iperf_stats_pkg;

  // stream side
  localparam int STACK_WIDTH = 64; // tcp stack data path
  localparam int KEEP_WIDTH = STACK_WIDTH / 8; // one keep bit per byte
  localparam int BEAT_BYTES_WIDTH = $clog2(KEEP_WIDTH + 1); // holds 0..8

  // counter widths
  localparam int BYTE_CNT_WIDTH = 48;
  localparam int EVENT_CNT_WIDTH = 32;
  localparam int CYCLE_CNT_WIDTH = 64; // run length and elapsed cycles

  // transmit status word, error field zero means the segment went out
  localparam int TX_STATUS_WIDTH = 64;
  localparam int TX_STS_ERR_MSB = 63;
  localparam int TX_STS_ERR_LSB = 62;

  // open-connection reply
  localparam int OPEN_STATUS_WIDTH = 24;
  localparam int OPEN_OK_BIT = 16; // set when the session opened

  // read request, length sits in the upper half
  localparam int READ_PKG_WIDTH = 32;
  localparam int READ_LEN_LSB = 16;
  localparam int READ_LEN_WIDTH = 16;

endpackage

`default_nettype wire

//--- src/run_control.sv
// run control for a throughput measurement: start edge, cycle timer, done pulse and idle flag
`timescale 1ns/1ps
`default_nettype none

module run_control (
  input  wire logic                                        ap_clk,
  input  wire logic                                        ap_rst_n,
  input  wire logic                                        ap_start,
  input  wire logic [iperf_stats_pkg::CYCLE_CNT_WIDTH-1:0] time_in_cycles,
  output logic                                             run_start,
  output logic                                             running,
  output logic                                             ap_done,
  output logic                                             ap_idle,
  output logic [iperf_stats_pkg::CYCLE_CNT_WIDTH-1:0]      exec_cycles
);

  import iperf_stats_pkg::*;

  logic                       ap_start_q; // ap_start one edge ago
  logic [CYCLE_CNT_WIDTH-1:0] run_len; // length latched at run start

  // rising edge of the level start
  assign run_start = ap_start & ~ap_start_q;

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      ap_start_q  <= 1'b0;
      running     <= 1'b0;
      ap_done     <= 1'b0;
      exec_cycles <= '0;
    end else begin
      ap_start_q <= ap_start;
      ap_done    <= 1'b0; // single cycle pulse
      if (run_start) begin
        running     <= 1'b1; // a new start restarts the timer
        exec_cycles <= '0;
      end else if (running) begin
        exec_cycles <= exec_cycles + 1'b1;
        if (exec_cycles == run_len) begin
          running <= 1'b0; // counter ends at T+1
          ap_done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (run_start) begin
      run_len <= time_in_cycles;
    end
  end

  // idle goes low for the whole run and comes back with done
  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      ap_idle <= 1'b1;
    end else if (run_start) begin
      ap_idle <= 1'b0;
    end else if (ap_done) begin
      ap_idle <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- src/tap_sampler.sv
// first statistics stage, turns observed stream handshakes into registered event strobes
`timescale 1ns/1ps
`default_nettype none

module tap_sampler (
  input  wire logic                                          ap_clk,
  input  wire logic                                          ap_rst_n,
  // receive data tap
  input  wire logic                                          rx_data_valid,
  input  wire logic                                          rx_data_ready,
  input  wire logic [iperf_stats_pkg::KEEP_WIDTH-1:0]        rx_data_keep,
  input  wire logic                                          rx_data_last,
  // transmit data tap
  input  wire logic                                          tx_data_valid,
  input  wire logic                                          tx_data_ready,
  input  wire logic [iperf_stats_pkg::KEEP_WIDTH-1:0]        tx_data_keep,
  input  wire logic                                          tx_data_last,
  // transmit command tap
  input  wire logic                                          tx_meta_valid,
  input  wire logic                                          tx_meta_ready,
  // transmit status tap
  input  wire logic                                          tx_status_valid,
  input  wire logic                                          tx_status_ready,
  input  wire logic [iperf_stats_pkg::TX_STATUS_WIDTH-1:0]   tx_status_data,
  // open reply tap
  input  wire logic                                          open_status_valid,
  input  wire logic                                          open_status_ready,
  input  wire logic [iperf_stats_pkg::OPEN_STATUS_WIDTH-1:0] open_status_data,
  // read request tap
  input  wire logic                                          read_pkg_valid,
  input  wire logic                                          read_pkg_ready,
  input  wire logic [iperf_stats_pkg::READ_PKG_WIDTH-1:0]    read_pkg_data,
  // registered events
  output logic                                               rx_beat,
  output logic [iperf_stats_pkg::BEAT_BYTES_WIDTH-1:0]       rx_beat_bytes,
  output logic                                               rx_pkt,
  output logic                                               tx_beat,
  output logic [iperf_stats_pkg::BEAT_BYTES_WIDTH-1:0]       tx_beat_bytes,
  output logic                                               tx_pkt,
  output logic                                               tx_cmd,
  output logic                                               tx_sts,
  output logic                                               tx_sts_good,
  output logic                                               open_sts,
  output logic                                               open_ok,
  output logic                                               rd_req,
  output logic [iperf_stats_pkg::READ_LEN_WIDTH-1:0]         rd_req_bytes
);

  import iperf_stats_pkg::*;

  logic rx_hs;
  logic tx_hs;
  logic meta_hs;
  logic sts_hs;
  logic open_hs;
  logic rd_hs;

  // bytes in a beat are the set keep bits, any pattern
  function automatic logic [BEAT_BYTES_WIDTH-1:0] count_keep(
    input logic [KEEP_WIDTH-1:0] keep
  );
    logic [BEAT_BYTES_WIDTH-1:0] n;
    n = '0;
    for (int i = 0; i < KEEP_WIDTH; i++) begin
      n = n + BEAT_BYTES_WIDTH'(keep[i]);
    end
    return n;
  endfunction

  assign rx_hs   = rx_data_valid & rx_data_ready;
  assign tx_hs   = tx_data_valid & tx_data_ready;
  assign meta_hs = tx_meta_valid & tx_meta_ready;
  assign sts_hs  = tx_status_valid & tx_status_ready;
  assign open_hs = open_status_valid & open_status_ready;
  assign rd_hs   = read_pkg_valid & read_pkg_ready;

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      rx_beat     <= 1'b0;
      rx_pkt      <= 1'b0;
      tx_beat     <= 1'b0;
      tx_pkt      <= 1'b0;
      tx_cmd      <= 1'b0;
      tx_sts      <= 1'b0;
      tx_sts_good <= 1'b0;
      open_sts    <= 1'b0;
      open_ok     <= 1'b0;
      rd_req      <= 1'b0;
    end else begin
      rx_beat     <= rx_hs;
      rx_pkt      <= rx_hs & rx_data_last;
      tx_beat     <= tx_hs;
      tx_pkt      <= tx_hs & tx_data_last;
      tx_cmd      <= meta_hs;
      tx_sts      <= sts_hs;
      tx_sts_good <= sts_hs & (tx_status_data[TX_STS_ERR_MSB:TX_STS_ERR_LSB] == '0);
      open_sts    <= open_hs;
      open_ok     <= open_hs & open_status_data[OPEN_OK_BIT];
      rd_req      <= rd_hs;
    end
  end

  // amounts ride along, only looked at with their strobe
  always_ff @(posedge ap_clk) begin
    rx_beat_bytes <= count_keep(rx_data_keep);
    tx_beat_bytes <= count_keep(tx_data_keep);
    rd_req_bytes  <= read_pkg_data[READ_LEN_LSB +: READ_LEN_WIDTH];
  end

endmodule

`default_nettype wire

//--- src/stat_accumulator.sv
// second statistics stage, sums the sampled events into run counters cleared at each start
`timescale 1ns/1ps
`default_nettype none

module stat_accumulator (
  input  wire logic                                         ap_clk,
  input  wire logic                                         ap_rst_n,
  input  wire logic                                         run_start,
  // events from the sampler
  input  wire logic                                         rx_beat,
  input  wire logic [iperf_stats_pkg::BEAT_BYTES_WIDTH-1:0] rx_beat_bytes,
  input  wire logic                                         rx_pkt,
  input  wire logic                                         tx_beat,
  input  wire logic [iperf_stats_pkg::BEAT_BYTES_WIDTH-1:0] tx_beat_bytes,
  input  wire logic                                         tx_pkt,
  input  wire logic                                         tx_cmd,
  input  wire logic                                         tx_sts,
  input  wire logic                                         tx_sts_good,
  input  wire logic                                         open_sts,
  input  wire logic                                         open_ok,
  input  wire logic                                         rd_req,
  input  wire logic [iperf_stats_pkg::READ_LEN_WIDTH-1:0]   rd_req_bytes,
  // counters
  output logic [iperf_stats_pkg::BYTE_CNT_WIDTH-1:0]        rx_bytes,
  output logic [iperf_stats_pkg::BYTE_CNT_WIDTH-1:0]        tx_bytes,
  output logic [iperf_stats_pkg::EVENT_CNT_WIDTH-1:0]       rx_pkts,
  output logic [iperf_stats_pkg::EVENT_CNT_WIDTH-1:0]       tx_pkts,
  output logic [iperf_stats_pkg::EVENT_CNT_WIDTH-1:0]       tx_cmds,
  output logic [iperf_stats_pkg::EVENT_CNT_WIDTH-1:0]       tx_stss,
  output logic [iperf_stats_pkg::EVENT_CNT_WIDTH-1:0]       tx_stss_good,
  output logic [iperf_stats_pkg::EVENT_CNT_WIDTH-1:0]       open_stss,
  output logic [iperf_stats_pkg::EVENT_CNT_WIDTH-1:0]       open_oks,
  output logic [iperf_stats_pkg::BYTE_CNT_WIDTH-1:0]        rd_req_total
);

  import iperf_stats_pkg::*;

  // byte counters
  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n || run_start) begin
      rx_bytes     <= '0; // clear wins over an event in flight
      tx_bytes     <= '0;
      rd_req_total <= '0;
    end else begin
      if (rx_beat) begin
        rx_bytes <= rx_bytes + BYTE_CNT_WIDTH'(rx_beat_bytes);
      end
      if (tx_beat) begin
        tx_bytes <= tx_bytes + BYTE_CNT_WIDTH'(tx_beat_bytes);
      end
      if (rd_req) begin
        rd_req_total <= rd_req_total + BYTE_CNT_WIDTH'(rd_req_bytes);
      end
    end
  end

  // event counters
  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n || run_start) begin
      rx_pkts      <= '0;
      tx_pkts      <= '0;
      tx_cmds      <= '0;
      tx_stss      <= '0;
      tx_stss_good <= '0;
      open_stss    <= '0;
      open_oks     <= '0;
    end else begin
      if (rx_pkt) begin
        rx_pkts <= rx_pkts + 1'b1;
      end
      if (tx_pkt) begin
        tx_pkts <= tx_pkts + 1'b1;
      end
      if (tx_cmd) begin
        tx_cmds <= tx_cmds + 1'b1;
      end
      if (tx_sts) begin
        tx_stss <= tx_stss + 1'b1;
      end
      if (tx_sts_good) begin
        tx_stss_good <= tx_stss_good + 1'b1; // error field was zero
      end
      if (open_sts) begin
        open_stss <= open_stss + 1'b1;
      end
      if (open_ok) begin
        open_oks <= open_oks + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/iperf_stats_top.sv
// top of the tcp throughput statistics core, run control plus the two stage counter pipeline
`timescale 1ns/1ps
`default_nettype none

module iperf_stats_top (
  input  wire logic                                          ap_clk,
  input  wire logic                                          ap_rst_n,
  input  wire logic                                          ap_start,
  input  wire logic [iperf_stats_pkg::CYCLE_CNT_WIDTH-1:0]   time_in_cycles,
  // stream taps
  input  wire logic                                          rx_data_valid,
  input  wire logic                                          rx_data_ready,
  input  wire logic [iperf_stats_pkg::KEEP_WIDTH-1:0]        rx_data_keep,
  input  wire logic                                          rx_data_last,
  input  wire logic                                          tx_data_valid,
  input  wire logic                                          tx_data_ready,
  input  wire logic [iperf_stats_pkg::KEEP_WIDTH-1:0]        tx_data_keep,
  input  wire logic                                          tx_data_last,
  input  wire logic                                          tx_meta_valid,
  input  wire logic                                          tx_meta_ready,
  input  wire logic                                          tx_status_valid,
  input  wire logic                                          tx_status_ready,
  input  wire logic [iperf_stats_pkg::TX_STATUS_WIDTH-1:0]   tx_status_data,
  input  wire logic                                          open_status_valid,
  input  wire logic                                          open_status_ready,
  input  wire logic [iperf_stats_pkg::OPEN_STATUS_WIDTH-1:0] open_status_data,
  input  wire logic                                          read_pkg_valid,
  input  wire logic                                          read_pkg_ready,
  input  wire logic [iperf_stats_pkg::READ_PKG_WIDTH-1:0]    read_pkg_data,
  // run status
  output logic                                               running,
  output logic                                               ap_done,
  output logic                                               ap_idle,
  output logic [iperf_stats_pkg::CYCLE_CNT_WIDTH-1:0]        exec_cycles,
  // statistics
  output logic [iperf_stats_pkg::BYTE_CNT_WIDTH-1:0]         rx_bytes,
  output logic [iperf_stats_pkg::BYTE_CNT_WIDTH-1:0]         tx_bytes,
  output logic [iperf_stats_pkg::EVENT_CNT_WIDTH-1:0]        rx_pkts,
  output logic [iperf_stats_pkg::EVENT_CNT_WIDTH-1:0]        tx_pkts,
  output logic [iperf_stats_pkg::EVENT_CNT_WIDTH-1:0]        tx_cmds,
  output logic [iperf_stats_pkg::EVENT_CNT_WIDTH-1:0]        tx_stss,
  output logic [iperf_stats_pkg::EVENT_CNT_WIDTH-1:0]        tx_stss_good,
  output logic [iperf_stats_pkg::EVENT_CNT_WIDTH-1:0]        open_stss,
  output logic [iperf_stats_pkg::EVENT_CNT_WIDTH-1:0]        open_oks,
  output logic [iperf_stats_pkg::BYTE_CNT_WIDTH-1:0]         rd_req_total
);

  import iperf_stats_pkg::*;

  logic                        run_start; // one cycle, clears the counters
  logic                        rx_beat;
  logic [BEAT_BYTES_WIDTH-1:0] rx_beat_bytes;
  logic                        rx_pkt;
  logic                        tx_beat;
  logic [BEAT_BYTES_WIDTH-1:0] tx_beat_bytes;
  logic                        tx_pkt;
  logic                        tx_cmd;
  logic                        tx_sts;
  logic                        tx_sts_good;
  logic                        open_sts;
  logic                        open_ok;
  logic                        rd_req;
  logic [READ_LEN_WIDTH-1:0]   rd_req_bytes;

  run_control u_run_control (
    .ap_clk         (ap_clk),
    .ap_rst_n       (ap_rst_n),
    .ap_start       (ap_start),
    .time_in_cycles (time_in_cycles),
    .run_start      (run_start),
    .running        (running),
    .ap_done        (ap_done),
    .ap_idle        (ap_idle),
    .exec_cycles    (exec_cycles)
  );

  tap_sampler u_tap_sampler (
    .ap_clk            (ap_clk),
    .ap_rst_n          (ap_rst_n),
    .rx_data_valid     (rx_data_valid),
    .rx_data_ready     (rx_data_ready),
    .rx_data_keep      (rx_data_keep),
    .rx_data_last      (rx_data_last),
    .tx_data_valid     (tx_data_valid),
    .tx_data_ready     (tx_data_ready),
    .tx_data_keep      (tx_data_keep),
    .tx_data_last      (tx_data_last),
    .tx_meta_valid     (tx_meta_valid),
    .tx_meta_ready     (tx_meta_ready),
    .tx_status_valid   (tx_status_valid),
    .tx_status_ready   (tx_status_ready),
    .tx_status_data    (tx_status_data),
    .open_status_valid (open_status_valid),
    .open_status_ready (open_status_ready),
    .open_status_data  (open_status_data),
    .read_pkg_valid    (read_pkg_valid),
    .read_pkg_ready    (read_pkg_ready),
    .read_pkg_data     (read_pkg_data),
    .rx_beat           (rx_beat),
    .rx_beat_bytes     (rx_beat_bytes),
    .rx_pkt            (rx_pkt),
    .tx_beat           (tx_beat),
    .tx_beat_bytes     (tx_beat_bytes),
    .tx_pkt            (tx_pkt),
    .tx_cmd            (tx_cmd),
    .tx_sts            (tx_sts),
    .tx_sts_good       (tx_sts_good),
    .open_sts          (open_sts),
    .open_ok           (open_ok),
    .rd_req            (rd_req),
    .rd_req_bytes      (rd_req_bytes)
  );

  stat_accumulator u_stat_accumulator (
    .ap_clk        (ap_clk),
    .ap_rst_n      (ap_rst_n),
    .run_start     (run_start),
    .rx_beat       (rx_beat),
    .rx_beat_bytes (rx_beat_bytes),
    .rx_pkt        (rx_pkt),
    .tx_beat       (tx_beat),
    .tx_beat_bytes (tx_beat_bytes),
    .tx_pkt        (tx_pkt),
    .tx_cmd        (tx_cmd),
    .tx_sts        (tx_sts),
    .tx_sts_good   (tx_sts_good),
    .open_sts      (open_sts),
    .open_ok       (open_ok),
    .rd_req        (rd_req),
    .rd_req_bytes  (rd_req_bytes),
    .rx_bytes      (rx_bytes),
    .tx_bytes      (tx_bytes),
    .rx_pkts       (rx_pkts),
    .tx_pkts       (tx_pkts),
    .tx_cmds       (tx_cmds),
    .tx_stss       (tx_stss),
    .tx_stss_good  (tx_stss_good),
    .open_stss     (open_stss),
    .open_oks      (open_oks),
    .rd_req_total  (rd_req_total)
  );

endmodule

`default_nettype wire

//--- tb/tb_clk_gen.sv
// clock and reset source for the statistics testbench, 20 ns clock with a 16 cycle reset
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic ap_clk,
  output logic ap_rst_n
);

  localparam int HALF_PERIOD_NS = 10;
  localparam int RESET_CYCLES = 16;

  initial begin
    ap_clk = 1'b0;
    forever #HALF_PERIOD_NS ap_clk = ~ap_clk;
  end

  initial begin
    ap_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge ap_clk);
    ap_rst_n <= 1'b1; // released on an edge, like the design's sync reset
  end

endmodule

`default_nettype wire

//--- tb/iperf_stats_chk.sv
// concurrent assertions on the run control outputs, bound into every run_control instance
`timescale 1ns/1ps
`default_nettype none

module iperf_stats_chk (
  input wire logic ap_clk,
  input wire logic ap_rst_n,
  input wire logic running,
  input wire logic ap_done,
  input wire logic ap_idle
);

  int fail_count = 0; // assertion failures so far

  done_one_cycle: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    ap_done |=> !ap_done)
    else begin
      fail_count++;
      $error("ap_done stayed high for more than one cycle");
    end

  done_after_run: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    ap_done |-> $past(running))
    else begin
      fail_count++;
      $error("ap_done rose without running high in the cycle before");
    end

  idle_not_running: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    !(running && ap_idle))
    else begin
      fail_count++;
      $error("running and ap_idle are high together");
    end

  // sync reset, so done is low one edge after any reset cycle
  done_low_in_reset: assert property (@(posedge ap_clk)
    !ap_rst_n |=> !ap_done)
    else begin
      fail_count++;
      $error("ap_done is high after a reset cycle");
    end

endmodule

bind run_control iperf_stats_chk u_iperf_stats_chk (
  .ap_clk   (ap_clk),
  .ap_rst_n (ap_rst_n),
  .running  (running),
  .ap_done  (ap_done),
  .ap_idle  (ap_idle)
);

`default_nettype wire

//--- tb/tb_iperf_stats.sv
// testbench top for the statistics core, runs a table of measurement runs and checks every counter
`timescale 1ns/1ps
`default_nettype none

module tb_iperf_stats;

  import iperf_stats_pkg::*;

  localparam int NUM_ROWS = 12;
  localparam int BEATS = 3; // handshakes per row
  localparam int CLK_PERIOD_NS = 20;
  localparam int DONE_SLACK = 8;
  localparam int TAP_RX = 0;
  localparam int TAP_TX = 1;
  localparam int TAP_META = 2;
  localparam int TAP_STS = 3;
  localparam int TAP_OPEN = 4;
  localparam int TAP_READ = 5;

  typedef struct {
    int                         tap;
    logic [KEEP_WIDTH-1:0]      keep;
    logic                       last;
    logic [TX_STATUS_WIDTH-1:0] data; // low bits feed the narrower taps
    int                         run_len;
  } row_t;

  logic ap_clk;
  logic ap_rst_n;
  logic ap_start;
  logic [CYCLE_CNT_WIDTH-1:0] time_in_cycles;
  logic rx_data_valid, rx_data_ready, rx_data_last;
  logic tx_data_valid, tx_data_ready, tx_data_last;
  logic [KEEP_WIDTH-1:0] rx_data_keep, tx_data_keep;
  logic tx_meta_valid, tx_meta_ready;
  logic tx_status_valid, tx_status_ready;
  logic [TX_STATUS_WIDTH-1:0] tx_status_data;
  logic open_status_valid, open_status_ready;
  logic [OPEN_STATUS_WIDTH-1:0] open_status_data;
  logic read_pkg_valid, read_pkg_ready;
  logic [READ_PKG_WIDTH-1:0] read_pkg_data;
  logic running, ap_done, ap_idle;
  logic [CYCLE_CNT_WIDTH-1:0] exec_cycles;
  logic [BYTE_CNT_WIDTH-1:0] rx_bytes, tx_bytes, rd_req_total;
  logic [EVENT_CNT_WIDTH-1:0] rx_pkts, tx_pkts, tx_cmds, tx_stss, tx_stss_good;
  logic [EVENT_CNT_WIDTH-1:0] open_stss, open_oks;

  logic [BYTE_CNT_WIDTH-1:0] exp_rx_bytes, exp_tx_bytes, exp_rd_req_total;
  logic [EVENT_CNT_WIDTH-1:0] exp_rx_pkts, exp_tx_pkts, exp_tx_cmds, exp_tx_stss;
  logic [EVENT_CNT_WIDTH-1:0] exp_tx_stss_good, exp_open_stss, exp_open_oks;

  row_t rows [NUM_ROWS];
  logic [15:0] lfsr_state;
  int errors;
  int tests_failed;

  tb_clk_gen u_tb_clk_gen (.ap_clk(ap_clk), .ap_rst_n(ap_rst_n));

  iperf_stats_top u_iperf_stats_top (.*);

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output int value);
    value = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value = (value << 1) | int'(lfsr_state[0]);
    end
  endtask

  function automatic string tap_name(input int tap);
    case (tap)
      TAP_RX:   return "rx data";
      TAP_TX:   return "tx data";
      TAP_META: return "tx meta";
      TAP_STS:  return "tx status";
      TAP_OPEN: return "open status";
      default:  return "read request";
    endcase
  endfunction

  task automatic load_table();
    rows[0]  = '{TAP_RX,   8'hff, 1'b0, 64'h0, 20};
    rows[1]  = '{TAP_RX,   8'h0f, 1'b1, 64'h0, 22}; // must not carry row 0
    rows[2]  = '{TAP_TX,   8'ha5, 1'b1, 64'h0, 24};
    rows[3]  = '{TAP_TX,   8'h01, 1'b0, 64'h0, 20};
    rows[4]  = '{TAP_META, 8'h00, 1'b0, 64'h0, 21};
    rows[5]  = '{TAP_STS,  8'h00, 1'b0, 64'h0000_0000_0000_1234, 23};
    rows[6]  = '{TAP_STS,  8'h00, 1'b0, 64'h8000_0000_0000_0001, 20};
    rows[7]  = '{TAP_STS,  8'h00, 1'b0, 64'h4000_0000_0000_0000, 26};
    rows[8]  = '{TAP_OPEN, 8'h00, 1'b0, 64'h0000_0000_0001_0005, 20};
    rows[9]  = '{TAP_OPEN, 8'h00, 1'b0, 64'h0000_0000_0000_ffff, 22};
    rows[10] = '{TAP_READ, 8'h00, 1'b0, 64'h0000_0000_05dc_0000, 25};
    rows[11] = '{TAP_READ, 8'h00, 1'b0, 64'h0000_0000_ffff_1234, 30};
  endtask

  // every counter starts a run at zero
  task automatic clear_expected();
    exp_rx_bytes = '0;
    exp_tx_bytes = '0;
    exp_rd_req_total = '0;
    exp_rx_pkts = '0;
    exp_tx_pkts = '0;
    exp_tx_cmds = '0;
    exp_tx_stss = '0;
    exp_tx_stss_good = '0;
    exp_open_stss = '0;
    exp_open_oks = '0;
  endtask

  task automatic compute_expected(input row_t r);
    clear_expected();
    case (r.tap)
      TAP_RX: begin
        exp_rx_bytes = BYTE_CNT_WIDTH'(BEATS * $countones(r.keep));
        if (r.last) exp_rx_pkts = EVENT_CNT_WIDTH'(BEATS);
      end
      TAP_TX: begin
        exp_tx_bytes = BYTE_CNT_WIDTH'(BEATS * $countones(r.keep));
        if (r.last) exp_tx_pkts = EVENT_CNT_WIDTH'(BEATS);
      end
      TAP_META: exp_tx_cmds = EVENT_CNT_WIDTH'(BEATS);
      TAP_STS: begin
        exp_tx_stss = EVENT_CNT_WIDTH'(BEATS);
        if (r.data[63:62] == 2'b00) exp_tx_stss_good = exp_tx_stss; // no error reported
      end
      TAP_OPEN: begin
        exp_open_stss = EVENT_CNT_WIDTH'(BEATS);
        if (r.data[16]) exp_open_oks = exp_open_stss; // session opened
      end
      default: exp_rd_req_total = BYTE_CNT_WIDTH'(BEATS) *
                                  BYTE_CNT_WIDTH'(r.data[31:16]);
    endcase
  endtask

  task automatic check_bytes(input string name, input logic [BYTE_CNT_WIDTH-1:0] got,
                             input logic [BYTE_CNT_WIDTH-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input logic [EVENT_CNT_WIDTH-1:0] got,
                             input logic [EVENT_CNT_WIDTH-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_cycles(input string name, input logic [CYCLE_CNT_WIDTH-1:0] got,
                              input logic [CYCLE_CNT_WIDTH-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_counters();
    check_bytes("rx_bytes", rx_bytes, exp_rx_bytes);
    check_bytes("tx_bytes", tx_bytes, exp_tx_bytes);
    check_bytes("rd_req_total", rd_req_total, exp_rd_req_total);
    check_count("rx_pkts", rx_pkts, exp_rx_pkts);
    check_count("tx_pkts", tx_pkts, exp_tx_pkts);
    check_count("tx_cmds", tx_cmds, exp_tx_cmds);
    check_count("tx_stss", tx_stss, exp_tx_stss);
    check_count("tx_stss_good", tx_stss_good, exp_tx_stss_good);
    check_count("open_stss", open_stss, exp_open_stss);
    check_count("open_oks", open_oks, exp_open_oks);
  endtask

  // only the chosen tap gets valid and ready, the others stay quiet
  task automatic drive_tap(input int tap, input logic v, input logic r);
    rx_data_valid     <= v & (tap == TAP_RX);
    rx_data_ready     <= r & (tap == TAP_RX);
    tx_data_valid     <= v & (tap == TAP_TX);
    tx_data_ready     <= r & (tap == TAP_TX);
    tx_meta_valid     <= v & (tap == TAP_META);
    tx_meta_ready     <= r & (tap == TAP_META);
    tx_status_valid   <= v & (tap == TAP_STS);
    tx_status_ready   <= r & (tap == TAP_STS);
    open_status_valid <= v & (tap == TAP_OPEN);
    open_status_ready <= r & (tap == TAP_OPEN);
    read_pkg_valid    <= v & (tap == TAP_READ);
    read_pkg_ready    <= r & (tap == TAP_READ);
  endtask

  task automatic fire_beats(input int tap);
    int stall;
    for (int b = 0; b < BEATS; b++) begin
      take_bits(2, stall); // 0..3 back-pressure cycles
      for (int c = 0; c < stall; c++) begin
        @(posedge ap_clk);
        drive_tap(tap, 1'b1, 1'b0);
      end
      @(posedge ap_clk);
      drive_tap(tap, 1'b1, 1'b1);
      @(posedge ap_clk);
      drive_tap(tap, 1'b0, 1'b0);
    end
  endtask

  // counts edges after the start edge until done shows up
  task automatic wait_done(input int idx, input int run_len);
    int   k;
    logic seen;
    k = 0;
    seen = 1'b0;
    while (!seen && k <= run_len + DONE_SLACK) begin
      @(posedge ap_clk);
      k++;
      @(negedge ap_clk);
      if (k == 1) begin
        check_flag("running", running, 1'b1);
        check_flag("ap_idle", ap_idle, 1'b0);
      end
      seen = ap_done;
    end
    if (!seen) begin
      errors++;
      $display("test %0d: ap_done did not arrive within %0d cycles of the start", idx, k);
    end else begin
      if (k != run_len + 1) begin
        errors++;
        $display("FAILED ap_done edge: got 0x%h expected 0x%h", k, run_len + 1);
      end
      check_cycles("exec_cycles", exec_cycles, CYCLE_CNT_WIDTH'(run_len + 1));
      check_flag("running", running, 1'b0);
      @(negedge ap_clk);
      check_flag("ap_done", ap_done, 1'b0);
      check_flag("ap_idle", ap_idle, 1'b1);
    end
  endtask

  task automatic run_row(input int idx);
    row_t r;
    int   errors_before;
    r = rows[idx];
    errors_before = errors;
    compute_expected(r);
    @(posedge ap_clk);
    ap_start         <= 1'b1;
    time_in_cycles   <= CYCLE_CNT_WIDTH'(r.run_len);
    rx_data_keep     <= r.keep;
    rx_data_last     <= r.last;
    tx_data_keep     <= r.keep;
    tx_data_last     <= r.last;
    tx_status_data   <= r.data;
    open_status_data <= r.data[OPEN_STATUS_WIDTH-1:0];
    read_pkg_data    <= r.data[READ_PKG_WIDTH-1:0];
    @(posedge ap_clk); // start edge, counters clear here
    ap_start <= 1'b0;
    fork
      fire_beats(r.tap);
      wait_done(idx + 1, r.run_len);
    join
    check_counters();
    if (errors == errors_before) begin
      $display("test %0d %s run of %0d cycles: ok", idx + 1, tap_name(r.tap), r.run_len);
    end else begin
      tests_failed++;
      $display("test %0d %s run of %0d cycles: %0d errors", idx + 1, tap_name(r.tap),
               r.run_len, errors - errors_before);
    end
  endtask

  initial begin
    longint total_cycles;
    longint watchdog_ns;
    errors = 0;
    tests_failed = 0;
    lfsr_state = 16'd75;
    load_table();
    ap_start = 1'b0;
    time_in_cycles = '0;
    rx_data_keep = '0;
    rx_data_last = 1'b0;
    tx_data_keep = '0;
    tx_data_last = 1'b0;
    tx_status_data = '0;
    open_status_data = '0;
    read_pkg_data = '0;
    drive_tap(TAP_RX, 1'b0, 1'b0);

    total_cycles = 32;
    foreach (rows[i]) total_cycles += longint'(rows[i].run_len + BEATS * 5 + 8);
    watchdog_ns = total_cycles * CLK_PERIOD_NS * 2;
    fork
      begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns with tests still running", watchdog_ns);
        $display("FAIL: see errors above");
        $finish;
      end
    join_none

    wait (ap_rst_n === 1'b1);
    @(negedge ap_clk);
    clear_expected(); // reset state is all zero
    check_flag("ap_idle", ap_idle, 1'b1);
    check_flag("running", running, 1'b0);
    check_flag("ap_done", ap_done, 1'b0);
    check_cycles("exec_cycles", exec_cycles, '0);
    check_counters();
    if (errors == 0) begin
      $display("test 0 reset state: ok");
    end else begin
      tests_failed++;
      $display("test 0 reset state: %0d errors", errors);
    end

    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(i);
    end

    // failures of the bound run control assertions
    errors += u_iperf_stats_top.u_run_control.u_iperf_stats_chk.fail_count;

    $display("%0d tests, %0d passed, %0d failed, %0d errors", NUM_ROWS + 1,
             NUM_ROWS + 1 - tests_failed, tests_failed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
src/iperf_stats_pkg.sv
src/run_control.sv
src/tap_sampler.sv
src/stat_accumulator.sv
src/iperf_stats_top.sv
tb/tb_clk_gen.sv
tb/iperf_stats_chk.sv
tb/tb_iperf_stats.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= tb_iperf_stats
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
